/* main_pkg.sv */
package main_pkg;

    // bus widths
    localparam int addr_w = 16;
    localparam int data_w = 8;
    localparam int ram_aw = 12;       // 4 KiB work RAM

    // decoded bus target
    typedef enum logic [3:0] {
        none,
        rom,
        ram,
        vram,
        objram,
        int_en,
        color,
        intshow,
        iow,
        snd_data,
        snd_on,
        ior,
        in5,
        in6,
        vscr
    } sel_e;

    // memory map, compared on the upper address bits
    localparam logic [addr_w-1:0] rom_base    = 16'h4000; // up to ffff
    localparam logic [addr_w-1:0] ram_base    = 16'h2000; // 2000-2fff
    localparam logic [addr_w-1:0] vram_base   = 16'h3000; // 3000-37ff
    localparam logic [addr_w-1:0] objram_base = 16'h3800; // 3800-3bff
    localparam logic [addr_w-1:0] io_base     = 16'h3c00; // 3c00-3fff

    // io block, picked by address bits 9:7
    localparam logic [2:0] io_sub      = 3'd0; // 3c00, split again by bits 6:4
    localparam logic [2:0] io_iow      = 3'd1; // 3c80
    localparam logic [2:0] io_snd_data = 3'd2; // 3d00
    localparam logic [2:0] io_snd_on   = 3'd3; // 3d80
    localparam logic [2:0] io_ior      = 3'd4; // 3e00
    localparam logic [2:0] io_in5      = 3'd5; // 3e80
    localparam logic [2:0] io_in6      = 3'd6; // 3f00

    // 3c00 sub-block, bits 6:4
    localparam logic [2:0] sub_int_en  = 3'd1; // 3c10
    localparam logic [2:0] sub_color   = 3'd2; // 3c20
    localparam logic [2:0] sub_intshow = 3'd3; // 3c30

    // bit positions in the addressable control latch
    localparam logic [2:0] latch_flip      = 3'd0;
    localparam logic [2:0] latch_irq_clrn  = 3'd1;
    localparam logic [2:0] latch_obj_frame = 3'd5;

    // floating data bus reads back high
    localparam logic [data_w-1:0] idle_byte = 8'hff;

endpackage

/* main_ram.sv */
module main_ram (
    input  logic                        clk,
    input  logic                        we,
    input  logic [main_pkg::ram_aw-1:0] addr,
    input  logic [main_pkg::data_w-1:0] wdata,
    output logic [main_pkg::data_w-1:0] rdata
);

    localparam int depth = 1 << main_pkg::ram_aw;

    logic [main_pkg::data_w-1:0] mem [0:depth-1];

    // read returns the old contents on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* main_cabinet.sv */
module main_cabinet (
    input  logic                        clk,
    input  logic [1:0]                  cab_sel,
    input  logic [1:0]                  start_button,
    input  logic [1:0]                  coin_input,
    input  logic [6:0]                  joystick1,
    input  logic [6:0]                  joystick2,
    input  logic                        service,
    output logic [main_pkg::data_w-1:0] cab_byte
);

    // board wiring swaps the direction pairs
    function automatic logic [main_pkg::data_w-1:0] joy_byte(input logic [6:0] j);
        return {1'b1, j[6:4], j[2], j[3], j[0], j[1]};
    endfunction

    // all inputs active low, unused bits pulled up
    always_ff @(posedge clk) begin
        case (cab_sel)
            2'd0:    cab_byte <= {3'b111, start_button, service, coin_input};
            2'd1:    cab_byte <= joy_byte(joystick1);
            2'd2:    cab_byte <= joy_byte(joystick2);
            default: cab_byte <= main_pkg::idle_byte;
        endcase
    end

endmodule

/* main_irq.sv */
module main_irq (
    input  logic clk,
    input  logic rst,
    input  logic lvbl,
    input  logic dip_pause,
    input  logic irq_clrn,
    output logic irq_n
);

    logic lvbl_q;
    logic vb_fall;
    logic req;

    assign vb_fall = lvbl_q && !lvbl;   // start of vertical blank

    always_ff @(posedge clk) begin
        if (rst) begin
            lvbl_q <= 1'b0;     // no false edge if lvbl is low out of reset
            req    <= 1'b0;
        end else begin
            lvbl_q <= lvbl;
            if (!irq_clrn) begin
                req <= 1'b0;    // clear wins and holds
            end else if (vb_fall && dip_pause) begin
                req <= 1'b1;
            end
        end
    end

    assign irq_n = ~req;

    a_irq_clr: assert property (@(posedge clk) disable iff (rst)
        !irq_clrn |=> irq_n)
        else $error("irq_n low while irq_clrn is held low");

endmodule

/* main_ctrl_regs.sv */
module main_ctrl_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ctrl_we,
    input  main_pkg::sel_e              ctrl_reg,
    input  logic [2:0]                  ctrl_idx,
    input  logic [main_pkg::data_w-1:0] ctrl_data,
    output logic                        flip,
    output logic                        obj_frame,
    output logic                        irq_clrn,
    output logic [3:0]                  pal_sel
);

    logic iow_we;
    logic color_we;

    assign iow_we   = ctrl_we && ctrl_reg == main_pkg::iow;
    assign color_we = ctrl_we && ctrl_reg == main_pkg::color;

    // addressable latch, address picks the bit and d0 is the value
    always_ff @(posedge clk) begin
        if (rst) begin
            flip      <= 1'b0;
            obj_frame <= 1'b0;
            irq_clrn  <= 1'b0;   // interrupt held off until software enables it
        end else if (iow_we) begin
            case (ctrl_idx)
                main_pkg::latch_flip:      flip      <= ctrl_data[0];
                main_pkg::latch_irq_clrn:  irq_clrn  <= ctrl_data[0];
                main_pkg::latch_obj_frame: obj_frame <= ctrl_data[0]; // object buffer swap
                default: ;  // latch outputs not wired on this board
            endcase
        end
    end

    // palette bank
    always_ff @(posedge clk) begin
        if (rst) begin
            pal_sel <= 4'd0;
        end else if (color_we) begin
            pal_sel <= ctrl_data[3:0];
        end
    end

endmodule

/* main_decoder.sv */
module main_decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        bus_valid,
    input  logic [main_pkg::addr_w-1:0] bus_addr,
    input  logic                        bus_rnw,
    input  logic [main_pkg::data_w-1:0] bus_wdata,
    output logic                        bus_ready,
    output logic [main_pkg::data_w-1:0] bus_rdata,
    output logic                        rom_cs,
    input  logic [main_pkg::data_w-1:0] rom_data,
    input  logic                        rom_ok,
    output logic                        ram_we,
    output logic [main_pkg::ram_aw-1:0] ram_addr,
    output logic [main_pkg::data_w-1:0] ram_wdata,
    input  logic [main_pkg::data_w-1:0] ram_rdata,
    output logic                        vram_cs,
    output logic                        objram_cs,
    output logic                        vscr_cs,
    output logic                        snd_data_cs,
    output logic                        snd_on_cs,
    input  logic [main_pkg::data_w-1:0] vram_dout,
    input  logic [main_pkg::data_w-1:0] obj_dout,
    input  logic [main_pkg::data_w-1:0] vscr_dout,
    output logic                        ctrl_we,
    output main_pkg::sel_e              ctrl_reg,
    output logic [2:0]                  ctrl_idx,
    output logic [main_pkg::data_w-1:0] ctrl_data,
    output logic [1:0]                  cab_sel,
    input  logic [main_pkg::data_w-1:0] cab_byte,
    input  logic [main_pkg::data_w-1:0] dipsw_a,
    input  logic [main_pkg::data_w-1:0] dipsw_b
);

    main_pkg::sel_e              sel;
    main_pkg::sel_e              sel_q;    // target of the access in flight
    logic                        accept;
    logic                        busy;     // set from acceptance through the ready cycle
    logic                        rom_rd;
    logic                        rom_pend;
    logic [main_pkg::data_w-1:0] rom_q;

    function automatic main_pkg::sel_e decode(input logic [main_pkg::addr_w-1:0] a);
        main_pkg::sel_e s;
        s = main_pkg::none;
        if (a >= main_pkg::rom_base) begin
            s = main_pkg::rom;
        end else if (a[15:12] == main_pkg::ram_base[15:12]) begin
            s = main_pkg::ram;
        end else if (a[15:11] == main_pkg::vram_base[15:11]) begin
            s = main_pkg::vram;
        end else if (a[15:10] == main_pkg::objram_base[15:10]) begin
            s = main_pkg::objram;
        end else if (a[15:10] == main_pkg::io_base[15:10]) begin
            case (a[9:7])
                main_pkg::io_sub: begin
                    case (a[6:4])
                        main_pkg::sub_int_en:  s = main_pkg::int_en;
                        main_pkg::sub_color:   s = main_pkg::color;
                        main_pkg::sub_intshow: s = main_pkg::intshow;
                        default:               s = main_pkg::none; // watchdog lives here
                    endcase
                end
                main_pkg::io_iow:      s = main_pkg::iow;
                main_pkg::io_snd_data: s = main_pkg::snd_data;
                main_pkg::io_snd_on:   s = main_pkg::snd_on;
                main_pkg::io_ior:      s = main_pkg::ior;
                main_pkg::io_in5:      s = main_pkg::in5;
                main_pkg::io_in6:      s = main_pkg::in6;
                default:               s = main_pkg::vscr; // 3f80
            endcase
        end
        return s;
    endfunction

    assign sel    = decode(bus_addr);   // master holds the address until ready
    assign accept = bus_valid && !busy;
    assign rom_rd = sel == main_pkg::rom && bus_rnw;

    // one-cycle strobes in the accepting cycle, rom_cs stretched until rom_ok
    assign rom_cs      = (accept && rom_rd) || rom_pend;
    assign ram_we      = accept && !bus_rnw && sel == main_pkg::ram;
    assign vram_cs     = accept && sel == main_pkg::vram;
    assign objram_cs   = accept && sel == main_pkg::objram;
    assign vscr_cs     = accept && sel == main_pkg::vscr;
    assign snd_data_cs = accept && sel == main_pkg::snd_data;
    assign snd_on_cs   = accept && sel == main_pkg::snd_on;
    assign ctrl_we     = accept && !bus_rnw && (sel == main_pkg::iow || sel == main_pkg::color);

    assign ram_addr  = bus_addr[main_pkg::ram_aw-1:0];
    assign ram_wdata = bus_wdata;
    assign ctrl_reg  = sel;
    assign ctrl_idx  = bus_addr[2:0];
    assign ctrl_data = bus_wdata;
    assign cab_sel   = bus_addr[1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            rom_pend  <= 1'b0;
            bus_ready <= 1'b0;
            sel_q     <= main_pkg::none;
        end else begin
            bus_ready <= 1'b0;
            if (bus_ready) busy <= 1'b0;
            if (accept) begin
                busy  <= 1'b1;
                sel_q <= sel;
            end
            if (rom_cs && rom_ok) begin
                rom_pend  <= 1'b0;
                bus_ready <= 1'b1;
            end else if (accept) begin
                if (rom_rd) rom_pend <= 1'b1;  // wait on the SDRAM
                else bus_ready <= 1'b1;        // fixed latency
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rom_cs && rom_ok) rom_q <= rom_data;
    end

    // every source is already registered by the acceptance edge
    always_comb begin
        case (sel_q)
            main_pkg::rom:     bus_rdata = rom_q;
            main_pkg::ram:     bus_rdata = ram_rdata;
            main_pkg::vram:    bus_rdata = vram_dout;
            main_pkg::objram:  bus_rdata = obj_dout;
            main_pkg::intshow: bus_rdata = vscr_dout;
            main_pkg::ior:     bus_rdata = cab_byte;
            main_pkg::in6:     bus_rdata = dipsw_a;
            main_pkg::in5:     bus_rdata = dipsw_b;
            default:           bus_rdata = main_pkg::idle_byte;
        endcase
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_we, vram_cs, objram_cs, vscr_cs, snd_data_cs, snd_on_cs, ctrl_we}))
        else $error("more than one select active");

    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(rom_cs) |-> bus_ready)
        else $error("rom_cs dropped before bus_ready");

endmodule

/* main_board.sv */
module main_board (
    input  logic                        clk,
    input  logic                        rst,
    // cpu bus
    input  logic                        bus_valid,
    input  logic [main_pkg::addr_w-1:0] bus_addr,
    input  logic                        bus_rnw,
    input  logic [main_pkg::data_w-1:0] bus_wdata,
    output logic                        bus_ready,
    output logic [main_pkg::data_w-1:0] bus_rdata,
    // rom
    output logic                        rom_cs,
    input  logic [main_pkg::data_w-1:0] rom_data,
    input  logic                        rom_ok,
    // video and sound
    output logic                        vram_cs,
    output logic                        objram_cs,
    output logic                        vscr_cs,
    output logic                        snd_data_cs,
    output logic                        snd_on_cs,
    input  logic [main_pkg::data_w-1:0] vram_dout,
    input  logic [main_pkg::data_w-1:0] obj_dout,
    input  logic [main_pkg::data_w-1:0] vscr_dout,
    // cabinet
    input  logic [1:0]                  start_button,
    input  logic [1:0]                  coin_input,
    input  logic [6:0]                  joystick1,
    input  logic [6:0]                  joystick2,
    input  logic                        service,
    input  logic                        dip_pause,
    input  logic [main_pkg::data_w-1:0] dipsw_a,
    input  logic [main_pkg::data_w-1:0] dipsw_b,
    input  logic                        lvbl,
    output logic                        flip,
    output logic                        obj_frame,
    output logic [3:0]                  pal_sel,
    output logic                        irq_n
);

    logic                        ram_we;
    logic [main_pkg::ram_aw-1:0] ram_addr;
    logic [main_pkg::data_w-1:0] ram_wdata;
    logic [main_pkg::data_w-1:0] ram_rdata;
    logic                        ctrl_we;
    main_pkg::sel_e              ctrl_reg;
    logic [2:0]                  ctrl_idx;
    logic [main_pkg::data_w-1:0] ctrl_data;
    logic                        irq_clrn;
    logic [1:0]                  cab_sel;
    logic [main_pkg::data_w-1:0] cab_byte;

    main_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .bus_valid   (bus_valid),
        .bus_addr    (bus_addr),
        .bus_rnw     (bus_rnw),
        .bus_wdata   (bus_wdata),
        .bus_ready   (bus_ready),
        .bus_rdata   (bus_rdata),
        .rom_cs      (rom_cs),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata),
        .vram_cs     (vram_cs),
        .objram_cs   (objram_cs),
        .vscr_cs     (vscr_cs),
        .snd_data_cs (snd_data_cs),
        .snd_on_cs   (snd_on_cs),
        .vram_dout   (vram_dout),
        .obj_dout    (obj_dout),
        .vscr_dout   (vscr_dout),
        .ctrl_we     (ctrl_we),
        .ctrl_reg    (ctrl_reg),
        .ctrl_idx    (ctrl_idx),
        .ctrl_data   (ctrl_data),
        .cab_sel     (cab_sel),
        .cab_byte    (cab_byte),
        .dipsw_a     (dipsw_a),
        .dipsw_b     (dipsw_b)
    );

    main_ctrl_regs u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .ctrl_we   (ctrl_we),
        .ctrl_reg  (ctrl_reg),
        .ctrl_idx  (ctrl_idx),
        .ctrl_data (ctrl_data),
        .flip      (flip),
        .obj_frame (obj_frame),
        .irq_clrn  (irq_clrn),
        .pal_sel   (pal_sel)
    );

    main_irq u_irq (
        .clk       (clk),
        .rst       (rst),
        .lvbl      (lvbl),
        .dip_pause (dip_pause),
        .irq_clrn  (irq_clrn),   // from the control latch
        .irq_n     (irq_n)
    );

    main_ram u_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    main_cabinet u_cabinet (
        .clk          (clk),
        .cab_sel      (cab_sel),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .cab_byte     (cab_byte)
    );

endmodule

/* tb_main_board.sv */
module tb_main_board;

    logic        clk, rst, bus_valid, bus_rnw, bus_ready, rom_cs, rom_ok;
    logic [15:0] bus_addr;
    logic [7:0]  bus_wdata, bus_rdata, rom_data, vram_dout, obj_dout, vscr_dout;
    logic [7:0]  dipsw_a, dipsw_b;
    logic        vram_cs, objram_cs, vscr_cs, snd_data_cs, snd_on_cs;
    logic [1:0]  start_button, coin_input;
    logic [6:0]  joystick1, joystick2;
    logic        service, dip_pause, lvbl, flip, obj_frame, irq_n;
    logic [3:0]  pal_sel;

    // reference state updated on the same edge as the DUT registers
    logic [7:0]  ram_ref [0:4095];
    logic        exp_flip, exp_obj, exp_clrn, exp_rom, exp_rd;
    logic [3:0]  exp_pal;
    logic [7:0]  exp_data;
    logic [5:0]  exp_sels;
    logic [5:0]  sels;
    int          rom_wait;
    int          rom_cnt;
    logic [15:0] addr_q [$];

    // decode sweep regions with the unmapped space below ram last
    logic [15:0] reg_lo [0:16] = '{16'h4000, 16'h2000, 16'h3000, 16'h3800, 16'h3c00, 16'h3c10,
        16'h3c20, 16'h3c30, 16'h3c40, 16'h3c80, 16'h3d00, 16'h3d80, 16'h3e00, 16'h3e80,
        16'h3f00, 16'h3f80, 16'h0000};
    logic [15:0] reg_hi [0:16] = '{16'hffff, 16'h2fff, 16'h37ff, 16'h3bff, 16'h3c0f, 16'h3c1f,
        16'h3c2f, 16'h3c3f, 16'h3c7f, 16'h3cff, 16'h3d7f, 16'h3dff, 16'h3e7f, 16'h3eff,
        16'h3f7f, 16'h3fff, 16'h1fff};
    logic [15:0] cab_addr [0:5] = '{16'h3e00, 16'h3e01, 16'h3e02, 16'h3e03, 16'h3e80, 16'h3f00};

    main_board u_dut (.*);

    assign sels = {rom_cs, vram_cs, objram_cs, vscr_cs, snd_data_cs, snd_on_cs};

    always #2 clk = ~clk;

    // slow rom answers after rom_wait cycles
    always @(posedge clk) begin
        if (rom_ok || !rom_cs) begin
            rom_ok  <= 1'b0;
            rom_cnt <= 0;
        end else if (rom_cnt == rom_wait) begin
            rom_ok   <= 1'b1;
            rom_data <= bus_addr[7:0] ^ bus_addr[15:8];
        end else begin
            rom_cnt <= rom_cnt + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [15:0] expv,
                               input logic [15:0] actv);
        abort_run($sformatf("** Error at time %0t: %s expected %0h, actual %0h",
                            $time, name, expv, actv));
    endtask

    // memory map as the board documents it
    function automatic main_pkg::sel_e region_of(input logic [15:0] a);
        if (a >= 16'h4000) return main_pkg::rom;
        if (a < 16'h2000) return main_pkg::none;
        if (a < 16'h3000) return main_pkg::ram;
        if (a < 16'h3800) return main_pkg::vram;
        if (a < 16'h3c00) return main_pkg::objram;
        case (a[9:7])
            3'd0: begin
                if (a[6:4] == 3'd1) return main_pkg::int_en;
                if (a[6:4] == 3'd2) return main_pkg::color;
                if (a[6:4] == 3'd3) return main_pkg::intshow;
                return main_pkg::none;                  // watchdog and gap
            end
            3'd1:    return main_pkg::iow;
            3'd2:    return main_pkg::snd_data;
            3'd3:    return main_pkg::snd_on;
            3'd4:    return main_pkg::ior;
            3'd5:    return main_pkg::in5;
            3'd6:    return main_pkg::in6;
            default: return main_pkg::vscr;
        endcase
    endfunction

    function automatic logic [7:0] cab_format(input logic [1:0] s);
        logic [6:0] j;
        j = (s == 2'd1) ? joystick1 : joystick2;
        case (s)
            2'd0:    return {3'b111, start_button, service, coin_input};
            2'd3:    return 8'hff;
            default: return {1'b1, j[6], j[5], j[4], j[2], j[3], j[0], j[1]};
        endcase
    endfunction

    function automatic logic [7:0] expected_read(input logic [15:0] a, input main_pkg::sel_e s);
        case (s)
            main_pkg::rom:     return a[7:0] ^ a[15:8];
            main_pkg::ram:     return ram_ref[a[11:0]];
            main_pkg::vram:    return vram_dout;
            main_pkg::objram:  return obj_dout;
            main_pkg::intshow: return vscr_dout;
            main_pkg::ior:     return cab_format(a[1:0]);
            main_pkg::in6:     return dipsw_a;
            main_pkg::in5:     return dipsw_b;
            default:           return 8'hff;
        endcase
    endfunction

    task automatic access(input logic [15:0] a, input logic rnw, input logic [7:0] d);
        main_pkg::sel_e s;
        int waited;
        s = region_of(a);
        waited = 0;
        @(posedge clk);
        bus_valid <= 1'b1;
        bus_addr  <= a;
        bus_rnw   <= rnw;
        bus_wdata <= d;
        exp_rd    <= rnw;
        exp_rom   <= rnw && s == main_pkg::rom;
        exp_data  <= expected_read(a, s);
        exp_sels  <= {rnw && s == main_pkg::rom, s == main_pkg::vram, s == main_pkg::objram,
                      s == main_pkg::vscr, s == main_pkg::snd_data, s == main_pkg::snd_on};
        rom_wait  <= $urandom_range(0, 5);
        @(posedge clk);     // acceptance edge
        if (!rnw && s == main_pkg::ram) ram_ref[a[11:0]] <= d;
        if (!rnw && s == main_pkg::color) exp_pal <= d[3:0];
        if (!rnw && s == main_pkg::iow) begin
            case (a[2:0])
                3'd0:    exp_flip <= d[0];
                3'd1:    exp_clrn <= d[0];
                3'd5:    exp_obj  <= d[0];
                default: ;
            endcase
        end
        while (!bus_ready) begin
            if (waited == 20) begin
                abort_run("bus_ready missing 20 cycles after an access started");
            end else begin
                waited++;
                @(posedge clk);
            end
        end
        bus_valid <= 1'b0;
    endtask

    task automatic shuffle_inputs();
        @(posedge clk);
        {start_button, coin_input, service} <= 5'($urandom);
        joystick1 <= 7'($urandom);
        joystick2 <= 7'($urandom);
        {dipsw_a, dipsw_b} <= 16'($urandom);
        {vram_dout, obj_dout, vscr_dout} <= 24'($urandom);
    endtask

    task automatic vblank_pulse();
        @(posedge clk);
        lvbl <= 1'b0;
        repeat (6) @(posedge clk);
        lvbl <= 1'b1;
    endtask

    a_reset: assert property (@(posedge clk) $fell(rst) |-> !bus_ready && irq_n && sels == '0)
        else abort_run("bus_ready, irq_n or a select left its reset value");
    a_sels: assert property (@(posedge clk) disable iff (rst) $rose(bus_valid) |-> sels == exp_sels)
        else value_error("sels", $sampled(exp_sels), $sampled(sels));
    a_sels_idle: assert property (@(posedge clk) disable iff (rst)
        !$rose(bus_valid) |-> sels[4:0] == '0)
        else abort_run("an external select was active outside an acceptance cycle");
    a_one_cycle: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_valid) && !exp_rom |=> bus_ready ##1 !bus_ready)
        else abort_run("a non-rom access did not complete in exactly one cycle");
    a_rom_hold: assert property (@(posedge clk) disable iff (rst) rom_cs && !rom_ok |=> rom_cs)
        else abort_run("rom_cs dropped before rom_ok");
    a_rom_done: assert property (@(posedge clk) disable iff (rst) rom_cs && rom_ok |=> bus_ready)
        else abort_run("bus_ready did not follow rom_ok");
    a_rom_early: assert property (@(posedge clk) disable iff (rst)
        bus_ready && exp_rom |-> $past(rom_ok))
        else abort_run("bus_ready came before rom_ok");
    a_rdata: assert property (@(posedge clk) disable iff (rst)
        bus_ready && exp_rd |-> bus_rdata == exp_data)
        else value_error("bus_rdata", $sampled(exp_data), $sampled(bus_rdata));
    a_flip: assert property (@(posedge clk) disable iff (rst) flip == exp_flip)
        else value_error("flip", $sampled(exp_flip), $sampled(flip));
    a_obj: assert property (@(posedge clk) disable iff (rst) obj_frame == exp_obj)
        else value_error("obj_frame", $sampled(exp_obj), $sampled(obj_frame));
    a_pal: assert property (@(posedge clk) disable iff (rst) pal_sel == exp_pal)
        else value_error("pal_sel", $sampled(exp_pal), $sampled(pal_sel));
    a_irq_set: assert property (@(posedge clk) disable iff (rst)
        $fell(lvbl) && dip_pause && exp_clrn |=> !irq_n)
        else value_error("irq_n", 16'd0, $sampled(irq_n));
    a_irq_clr: assert property (@(posedge clk) disable iff (rst) !exp_clrn |=> irq_n)
        else value_error("irq_n", 16'd1, $sampled(irq_n));
    a_irq_pause: assert property (@(posedge clk) disable iff (rst)
        $fell(irq_n) |-> $past(dip_pause && exp_clrn))
        else abort_run("irq_n fell without dip_pause and irq_clrn both set");

    initial begin
        logic [15:0] a;
        void'($urandom(32'h2c9a_57c6));
        clk       = 1'b0;
        rst       = 1'b1;
        bus_valid = 1'b0;
        bus_addr  = '0;
        bus_rnw   = 1'b1;
        bus_wdata = '0;
        rom_ok    = 1'b0;
        rom_data  = '0;
        {vram_dout, obj_dout, vscr_dout, dipsw_a, dipsw_b} = '1;
        {start_button, coin_input, joystick1, joystick2, service} = '1;
        dip_pause = 1'b1;
        lvbl      = 1'b1;
        {exp_flip, exp_obj, exp_clrn, exp_rom, exp_rd, exp_pal} = '0;
        exp_data  = '0;
        exp_sels  = '0;
        rom_wait  = 0;
        rom_cnt   = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        shuffle_inputs();
        for (int r = 0; r < 17; r++) begin
            repeat (3) begin
                a = reg_lo[r] + 16'($urandom_range(0, reg_hi[r] - reg_lo[r]));
                access(a, region_of(a) != main_pkg::ram, 8'($urandom));
            end
        end
        repeat (32) begin   // work ram fill for the read back below
            a = 16'($urandom_range(16'h2000, 16'h2fff));
            addr_q.push_back(a);
            access(a, 1'b0, 8'($urandom));
        end
        foreach (addr_q[i]) access(addr_q[i], 1'b1, 8'h00);
        repeat (12) access(16'($urandom_range(16'h4000, 16'hffff)), 1'b1, 8'h00);
        repeat (3) begin
            shuffle_inputs();
            foreach (cab_addr[i]) access(cab_addr[i], 1'b1, 8'h00);
        end
        repeat (24) begin
            if ($urandom_range(0, 3) == 0) access(16'h3c20, 1'b0, 8'($urandom));
            else access(16'h3c80 + 16'($urandom_range(0, 7)), 1'b0, 8'($urandom));
        end
        // every latch index set and then cleared, upper palette bits ignored
        for (int i = 0; i < 8; i++) begin
            access(16'h3c80 + 16'(i), 1'b0, 8'h01);
        end
        access(16'h3c20, 1'b0, 8'ha5);
        for (int i = 0; i < 8; i++) begin
            access(16'h3c80 + 16'(i), 1'b0, 8'hfe);
        end
        access(16'h3c20, 1'b0, 8'h5a);
        access(16'h3c81, 1'b0, 8'h01);  // enable before vblank
        vblank_pulse();
        access(16'h3c81, 1'b0, 8'h00);
        access(16'h3c81, 1'b0, 8'h01);
        @(posedge clk);
        dip_pause <= 1'b0;              // paused so no interrupt expected
        vblank_pulse();
        repeat (4) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* vlog.f */
main_pkg.sv
main_ram.sv
main_cabinet.sv
main_irq.sv
main_ctrl_regs.sv
main_decoder.sv
main_board.sv
tb_main_board.sv
